//--- ninjin_burst_seq.sv
module ninjin_burst_seq #(
  parameter int BURST_LEN = 16
) (
  input  logic                  clk,
  input  logic                  xrst,
  input  logic                  start,
  input  ninjin_pkg::ddr_mode_t mode,
  input  ninjin_pkg::haddr_t    host_base,
  input  ninjin_pkg::laddr_t    local_base,
  input  logic [7:0]            burst_num,
  input  logic                  burst_done,
  input  ninjin_pkg::err_t      burst_err,
  output logic                  ddr_req,
  output ninjin_pkg::ddr_mode_t ddr_mode,
  output ninjin_pkg::haddr_t    haddr,
  output ninjin_pkg::laddr_t    laddr,
  output logic                  busy,
  output logic                  done,
  output ninjin_pkg::err_t      err
);

  // host stride per burst in bytes
  localparam int unsigned HSTRIDE = BURST_LEN * (ninjin_pkg::DATA_WIDTH / 8);

  ninjin_pkg::seq_state_t state;
  logic [7:0]             remain;
  logic                   accept;
  logic                   last_burst;

  assign accept     = (state == ninjin_pkg::S_WAIT) && start && !busy;
  assign last_burst = (remain == 8'd1);

  //============================================================
  // command fsm
  //============================================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state   <= ninjin_pkg::S_WAIT;
      ddr_req <= 1'b0;
      busy    <= 1'b0;
      done    <= 1'b0;
      err     <= '0;
      remain  <= '0;
    end else begin
      done <= 1'b0;
      // busy covers the done cycle, then falls
      if (done) begin
        busy <= 1'b0;
      end
      case (state)
        ninjin_pkg::S_WAIT: begin
          if (accept) begin
            busy   <= 1'b1;
            err    <= '0;
            remain <= burst_num;
            if (burst_num == 8'd0) begin
              done <= 1'b1;
            end else begin
              ddr_req <= 1'b1;
              state   <= ninjin_pkg::S_RUN;
            end
          end
        end
        ninjin_pkg::S_ISSUE: begin
          ddr_req <= 1'b1;
          state   <= ninjin_pkg::S_RUN;
        end
        ninjin_pkg::S_RUN: begin
          if (burst_done) begin
            ddr_req <= 1'b0;
            err     <= err | burst_err;
            remain  <= remain - 8'd1;
            if (last_burst) begin
              done  <= 1'b1;
              state <= ninjin_pkg::S_WAIT;
            end else begin
              state <= ninjin_pkg::S_ISSUE;
            end
          end
        end
        default: begin
          state <= ninjin_pkg::S_WAIT;
        end
      endcase
    end
  end

  //============================================================
  // burst addresses
  //============================================================
  always_ff @(posedge clk) begin
    if (accept) begin
      ddr_mode <= mode;
      haddr    <= host_base;
      laddr    <= local_base;
    end else if (state == ninjin_pkg::S_RUN && burst_done) begin
      haddr <= haddr + ninjin_pkg::haddr_t'(HSTRIDE);
      laddr <= laddr + ninjin_pkg::laddr_t'(BURST_LEN);
    end
  end

endmodule

//--- ninjin_image_dma.sv
module ninjin_image_dma #(
  parameter int BURST_LEN = 16,
  parameter int MEMSIZE   = 12
) (
  input  logic                  clk,
  input  logic                  xrst,
  input  logic                  start,
  input  ninjin_pkg::ddr_mode_t mode,
  input  ninjin_pkg::haddr_t    host_base,
  input  ninjin_pkg::laddr_t    local_base,
  input  logic [7:0]            burst_num,
  output logic                  busy,
  output logic                  done,
  output ninjin_pkg::err_t      err,
  input  logic                  awready,
  input  logic                  wready,
  input  logic [1:0]            bresp,
  input  logic                  bvalid,
  input  logic                  arready,
  input  ninjin_pkg::word_t     rdata,
  input  logic [1:0]            rresp,
  input  logic                  rlast,
  input  logic                  rvalid,
  output logic                  awvalid,
  output ninjin_pkg::haddr_t    awaddr,
  output logic [7:0]            awlen,
  output logic [2:0]            awsize,
  output logic [1:0]            awburst,
  output logic                  wvalid,
  output ninjin_pkg::word_t     wdata,
  output logic [3:0]            wstrb,
  output logic                  wlast,
  output logic                  bready,
  output logic                  arvalid,
  output ninjin_pkg::haddr_t    araddr,
  output logic [7:0]            arlen,
  output logic [2:0]            arsize,
  output logic [1:0]            arburst,
  output logic                  rready
);

  // sequencer to master
  logic                  ddr_req;
  ninjin_pkg::ddr_mode_t ddr_mode;
  ninjin_pkg::haddr_t    haddr;
  ninjin_pkg::laddr_t    laddr;
  logic                  burst_done;
  ninjin_pkg::err_t      burst_err;

  // master to local ram
  logic                  ddr_we;
  ninjin_pkg::laddr_t    ddr_waddr;
  ninjin_pkg::word_t     ddr_wdata;
  ninjin_pkg::laddr_t    ddr_raddr;
  ninjin_pkg::word_t     ddr_rdata;

  ninjin_burst_seq #(
    .BURST_LEN (BURST_LEN)
  ) u_seq (
    .clk        (clk),
    .xrst       (xrst),
    .start      (start),
    .mode       (mode),
    .host_base  (host_base),
    .local_base (local_base),
    .burst_num  (burst_num),
    .burst_done (burst_done),
    .burst_err  (burst_err),
    .ddr_req    (ddr_req),
    .ddr_mode   (ddr_mode),
    .haddr      (haddr),
    .laddr      (laddr),
    .busy       (busy),
    .done       (done),
    .err        (err)
  );

  ninjin_m_axi_image #(
    .BURST_LEN (BURST_LEN)
  ) u_axi (
    .clk        (clk),
    .xrst       (xrst),
    .ddr_req    (ddr_req),
    .ddr_mode   (ddr_mode),
    .haddr      (haddr),
    .laddr      (laddr),
    .ddr_rdata  (ddr_rdata),
    .awready    (awready),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rlast      (rlast),
    .rvalid     (rvalid),
    .burst_done (burst_done),
    .burst_err  (burst_err),
    .awvalid    (awvalid),
    .awaddr     (awaddr),
    .awlen      (awlen),
    .awsize     (awsize),
    .awburst    (awburst),
    .wvalid     (wvalid),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wlast      (wlast),
    .bready     (bready),
    .arvalid    (arvalid),
    .araddr     (araddr),
    .arlen      (arlen),
    .arsize     (arsize),
    .arburst    (arburst),
    .rready     (rready),
    .ddr_we     (ddr_we),
    .ddr_waddr  (ddr_waddr),
    .ddr_wdata  (ddr_wdata),
    .ddr_raddr  (ddr_raddr)
  );

  ninjin_image_ram #(
    .MEMSIZE (MEMSIZE)
  ) u_ram (
    .clk   (clk),
    .we    (ddr_we),
    .waddr (ddr_waddr),
    .wdata (ddr_wdata),
    .raddr (ddr_raddr),
    .rdata (ddr_rdata)
  );

endmodule

//--- ninjin_image_ram.sv
module ninjin_image_ram #(
  parameter int MEMSIZE = 12
) (
  input  logic               clk,
  input  logic               we,
  input  ninjin_pkg::laddr_t waddr,
  input  ninjin_pkg::word_t  wdata,
  input  ninjin_pkg::laddr_t raddr,
  output ninjin_pkg::word_t  rdata
);

  localparam int DEPTH = 2 ** MEMSIZE;

  ninjin_pkg::word_t mem [0:DEPTH-1];

  // write port, filled by the axi read side
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read port, one cycle latency
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

//--- ninjin_m_axi_image.sv
module ninjin_m_axi_image #(
  parameter int BURST_LEN = 16
) (
  input  logic                  clk,
  input  logic                  xrst,
  input  logic                  ddr_req,
  input  ninjin_pkg::ddr_mode_t ddr_mode,
  input  ninjin_pkg::haddr_t    haddr,
  input  ninjin_pkg::laddr_t    laddr,
  input  ninjin_pkg::word_t     ddr_rdata,
  input  logic                  awready,
  input  logic                  wready,
  input  logic [1:0]            bresp,
  input  logic                  bvalid,
  input  logic                  arready,
  input  ninjin_pkg::word_t     rdata,
  input  logic [1:0]            rresp,
  input  logic                  rlast,
  input  logic                  rvalid,
  output logic                  burst_done,
  output ninjin_pkg::err_t      burst_err,
  output logic                  awvalid,
  output ninjin_pkg::haddr_t    awaddr,
  output logic [7:0]            awlen,
  output logic [2:0]            awsize,
  output logic [1:0]            awburst,
  output logic                  wvalid,
  output ninjin_pkg::word_t     wdata,
  output logic [3:0]            wstrb,
  output logic                  wlast,
  output logic                  bready,
  output logic                  arvalid,
  output ninjin_pkg::haddr_t    araddr,
  output logic [7:0]            arlen,
  output logic [2:0]            arsize,
  output logic [1:0]            arburst,
  output logic                  rready,
  output logic                  ddr_we,
  output ninjin_pkg::laddr_t    ddr_waddr,
  output ninjin_pkg::word_t     ddr_wdata,
  output ninjin_pkg::laddr_t    ddr_raddr
);

  localparam int IDX_W = (BURST_LEN > 1) ? ninjin_pkg::clogb2(BURST_LEN - 1) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(BURST_LEN - 1);

  ninjin_pkg::chan_state_t w_state;
  ninjin_pkg::chan_state_t r_state;
  logic                    req_q;
  logic                    req_pulse;
  logic                    wreq_pulse;
  logic                    rreq_pulse;
  logic                    w_launch;
  logic                    r_launch;
  logic                    wnext;
  logic                    rnext;
  logic                    w_end;
  logic                    r_end;
  logic                    err_wresp;
  logic                    err_rresp;
  logic [IDX_W-1:0]        widx;
  logic [IDX_W-1:0]        ridx;
  ninjin_pkg::laddr_t      rd_addr;
  ninjin_pkg::laddr_t      wr_base;
  ninjin_pkg::err_t        err_q;

  //============================================================
  // request edge and channel fsms
  //============================================================
  assign req_pulse  = ddr_req && !req_q;
  assign wreq_pulse = req_pulse && ddr_mode == ninjin_pkg::DDR_WRITE
                      && w_state == ninjin_pkg::S_IDLE;
  assign rreq_pulse = req_pulse && ddr_mode == ninjin_pkg::DDR_READ
                      && r_state == ninjin_pkg::S_IDLE;

  assign wnext = wvalid && wready;
  assign rnext = rvalid && rready;
  assign w_end = w_state == ninjin_pkg::S_BUSY && bvalid && bready;
  assign r_end = r_state == ninjin_pkg::S_BUSY && rnext && rlast;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      req_q      <= 1'b0;
      w_state    <= ninjin_pkg::S_IDLE;
      r_state    <= ninjin_pkg::S_IDLE;
      w_launch   <= 1'b0;
      r_launch   <= 1'b0;
      burst_done <= 1'b0;
    end else begin
      req_q      <= ddr_req;
      w_launch   <= wreq_pulse;
      r_launch   <= rreq_pulse;
      burst_done <= w_end || r_end;
      if (wreq_pulse) begin
        w_state <= ninjin_pkg::S_BUSY;
      end else if (w_end) begin
        w_state <= ninjin_pkg::S_IDLE;
      end
      if (rreq_pulse) begin
        r_state <= ninjin_pkg::S_BUSY;
      end else if (r_end) begin
        r_state <= ninjin_pkg::S_IDLE;
      end
    end
  end

  //============================================================
  // write address and data
  //============================================================
  assign awlen   = 8'(BURST_LEN - 1);
  assign awsize  = 3'(ninjin_pkg::clogb2(ninjin_pkg::DATA_WIDTH / 8 - 1));
  assign awburst = 2'b01;
  assign wstrb   = '1;
  assign wlast   = wvalid && widx == LAST_IDX;

  // ram output is the current beat, next word fetched on accept
  assign wdata     = ddr_rdata;
  assign ddr_raddr = wnext ? rd_addr + 1'b1 : rd_addr;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
      widx    <= '0;
    end else begin
      if (w_launch) begin
        awvalid <= 1'b1;
      end else if (awready) begin
        awvalid <= 1'b0;
      end
      if (w_launch) begin
        wvalid <= 1'b1;
      end else if (wnext && wlast) begin
        wvalid <= 1'b0;
      end
      if (w_launch) begin
        bready <= 1'b1;
      end else if (w_end) begin
        bready <= 1'b0;
      end
      if (wreq_pulse) begin
        widx <= '0;
      end else if (wnext && widx != LAST_IDX) begin
        widx <= widx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wreq_pulse) begin
      awaddr  <= haddr;
      rd_addr <= laddr;
    end else if (wnext) begin
      rd_addr <= rd_addr + 1'b1;
    end
  end

  //============================================================
  // read address and data
  //============================================================
  assign arlen   = 8'(BURST_LEN - 1);
  assign arsize  = 3'(ninjin_pkg::clogb2(ninjin_pkg::DATA_WIDTH / 8 - 1));
  assign arburst = 2'b01;

  // every accepted beat goes straight into local ram
  assign ddr_we    = rnext;
  assign ddr_waddr = wr_base + ninjin_pkg::laddr_t'(ridx);
  assign ddr_wdata = rdata;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      arvalid <= 1'b0;
      rready  <= 1'b0;
      ridx    <= '0;
    end else begin
      if (r_launch) begin
        arvalid <= 1'b1;
      end else if (arready) begin
        arvalid <= 1'b0;
      end
      if (r_launch) begin
        rready <= 1'b1;
      end else if (r_end) begin
        rready <= 1'b0;
      end
      if (rreq_pulse) begin
        ridx <= '0;
      end else if (rnext && ridx != LAST_IDX) begin
        ridx <= ridx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rreq_pulse) begin
      araddr  <= haddr;
      wr_base <= laddr;
    end
  end

  //============================================================
  // response errors
  //============================================================
  assign err_wresp = bvalid && bready && bresp[1];
  assign err_rresp = rnext && rresp[1];
  assign burst_err = err_q;

  // sticky for the burst, reported with burst_done
  always_ff @(posedge clk) begin
    if (!xrst) begin
      err_q <= '0;
    end else if (wreq_pulse || rreq_pulse) begin
      err_q <= '0;
    end else if (err_wresp || err_rresp) begin
      err_q <= err_q | {err_wresp, err_rresp, 1'b1};
    end
  end

endmodule

//--- ninjin_pkg.sv
package ninjin_pkg;

  // fixed widths for the typedefs below
  localparam int DATA_WIDTH  = 32;
  localparam int HADDR_WIDTH = 32;
  localparam int LADDR_WIDTH = 12;

  typedef enum logic {
    DDR_WRITE,
    DDR_READ
  } ddr_mode_t;

  typedef logic [DATA_WIDTH-1:0]  word_t;
  typedef logic [HADDR_WIDTH-1:0] haddr_t;
  typedef logic [LADDR_WIDTH-1:0] laddr_t;

  // {write resp error, read resp error, any error}
  typedef logic [2:0] err_t;

  typedef enum logic {
    S_IDLE,
    S_BUSY
  } chan_state_t;

  typedef enum logic [1:0] {
    S_WAIT,
    S_ISSUE,
    S_RUN
  } seq_state_t;

  // bits needed to hold value
  function automatic int clogb2(input int value);
    int bits;
    bits = 0;
    for (int v = value; v > 0; v = v >> 1) begin
      bits = bits + 1;
    end
    return bits;
  endfunction

endpackage

//--- ninjin_testdata.txt
// word 0: command count; then per command: mode host_base local_base burst_num fail_burst
// exp_err chk_src (mode 1 read, 0 write; fail_burst ff none; chk_src ffff skips copy check)
6
1 00000000 000 02 ff 0 ffff
0 00000800 000 02 ff 0 0000
0 00000c00 000 01 04 5 ffff
1 00000400 100 01 05 3 ffff
1 00000000 000 00 ff 0 ffff
0 00000a00 010 01 ff 0 0010
// initial host words 0..31, source of the copies
@40
3f2a0c11 8d41e702 51b09c3e 07e6a4d5 c9137f68 24ad5b90 e0f13c47 9b6d2e01
6a0457cf f38e19b2 15c7d460 a2e9b87d 4e71036a d03bfa25 7b5c8e94 28f6a1d3
b14e6d72 0c9a35e8 e75f2b06 593d804f 86b2c91a 3ce7f4b5 f10856de 4da3e920
92c41b7f 6f1d0ac3 a8b3657e 1e5fd294 c7206e3b 70e89d51 0b4af7c6 de93125a

//--- run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_ninjin_image_dma -f sim.f -o sim_top
./obj_dir/sim_top | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
  echo "simulation reported failure, see sim.log"
  exit 1
fi
echo "simulation finished without failure"

//--- sim.f
ninjin_pkg.sv
ninjin_image_ram.sv
ninjin_burst_seq.sv
ninjin_m_axi_image.sv
ninjin_image_dma.sv
tb_axi_mem.sv
tb_ninjin_image_dma.sv

//--- tb_axi_mem.sv
module tb_axi_mem #(
  parameter int BURST_LEN = 16
) (
  input  logic               clk,
  input  logic               xrst,
  input  logic [7:0]         fail_burst,
  input  logic               awvalid,
  input  ninjin_pkg::haddr_t awaddr,
  output logic               awready,
  input  logic               wvalid,
  input  ninjin_pkg::word_t  wdata,
  input  logic               wlast,
  output logic               wready,
  output logic [1:0]         bresp,
  output logic               bvalid,
  input  logic               bready,
  input  logic               arvalid,
  input  ninjin_pkg::haddr_t araddr,
  output logic               arready,
  output ninjin_pkg::word_t  rdata,
  output logic [1:0]         rresp,
  output logic               rlast,
  output logic               rvalid,
  input  logic               rready
);

  // host memory, 1024 words, loaded by the testbench top
  ninjin_pkg::word_t mem [0:1023];

  // per-channel grant bits, redrawn every cycle
  logic [4:0] go;
  logic       w_open;
  logic       w_fin;
  logic       w_fail;
  logic       r_open;
  logic       r_fail;
  logic [9:0] wptr;
  logic [9:0] rptr;
  logic [8:0] rcnt;
  logic [7:0] burst_idx;

  assign awready = !w_open && go[0];
  assign wready  = w_open && !w_fin && go[1];
  assign arready = !r_open && go[3];

  always @(posedge clk) begin
    if (!xrst) begin
      go        <= '0;
      w_open    <= 1'b0;
      w_fin     <= 1'b0;
      w_fail    <= 1'b0;
      r_open    <= 1'b0;
      r_fail    <= 1'b0;
      wptr      <= '0;
      rptr      <= '0;
      rcnt      <= '0;
      burst_idx <= '0;
      bvalid    <= 1'b0;
      bresp     <= 2'b00;
      rvalid    <= 1'b0;
      rlast     <= 1'b0;
      rresp     <= 2'b00;
      rdata     <= '0;
    end else begin
      // roughly one stall in four on each channel
      for (int i = 0; i < 5; i++) begin
        go[i] <= ($urandom % 4) != 0;
      end

      //============================================================
      // write side
      //============================================================
      if (awvalid && awready) begin
        w_open    <= 1'b1;
        wptr      <= awaddr[11:2];
        w_fail    <= burst_idx == fail_burst;
        burst_idx <= burst_idx + 8'd1;
      end
      if (wvalid && wready) begin
        mem[wptr] <= wdata;
        wptr      <= wptr + 10'd1;
        if (wlast) begin
          w_fin <= 1'b1;
        end
      end
      if (w_fin && !bvalid && go[2]) begin
        bvalid <= 1'b1;
        bresp  <= w_fail ? 2'b10 : 2'b00;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
        w_open <= 1'b0;
        w_fin  <= 1'b0;
      end

      //============================================================
      // read side
      //============================================================
      if (arvalid && arready) begin
        r_open    <= 1'b1;
        rptr      <= araddr[11:2];
        rcnt      <= '0;
        r_fail    <= burst_idx == fail_burst;
        burst_idx <= burst_idx + 8'd1;
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
        if (rlast) begin
          r_open <= 1'b0;
        end
      end
      // next beat only once the previous one is gone
      if (r_open && rcnt != 9'(BURST_LEN) && (!rvalid || rready) && go[4]) begin
        rvalid <= 1'b1;
        rdata  <= mem[rptr];
        rresp  <= r_fail ? 2'b10 : 2'b00;
        rlast  <= rcnt == 9'(BURST_LEN - 1);
        rptr   <= rptr + 10'd1;
        rcnt   <= rcnt + 9'd1;
      end
    end
  end

endmodule

//--- tb_ninjin_image_dma.sv
module tb_ninjin_image_dma;

  localparam int BURST_LEN  = 16;
  localparam int MEMSIZE    = 12;
  localparam int CMD_FIELDS = 7;
  localparam int HOST_OFS   = 64;
  localparam int N_HOST     = 32;

  // fixed axi fields for full-width incr bursts
  localparam logic [2:0] SIZE_EXP   = 3'($clog2($bits(ninjin_pkg::word_t) / 8));
  localparam logic [1:0] BURST_INCR = 2'b01;
  localparam logic [3:0] STRB_ALL   = 4'hf;

  logic                  clk;
  logic                  xrst;
  logic                  start;
  ninjin_pkg::ddr_mode_t mode;
  ninjin_pkg::haddr_t    host_base;
  ninjin_pkg::laddr_t    local_base;
  logic [7:0]            burst_num;
  logic                  busy;
  logic                  done;
  ninjin_pkg::err_t      err;
  logic [7:0]            fail_burst;

  logic                  awready;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  arready;
  ninjin_pkg::word_t     rdata;
  logic [1:0]            rresp;
  logic                  rlast;
  logic                  rvalid;
  logic                  awvalid;
  ninjin_pkg::haddr_t    awaddr;
  logic [7:0]            awlen;
  logic [2:0]            awsize;
  logic [1:0]            awburst;
  logic                  wvalid;
  ninjin_pkg::word_t     wdata;
  logic [3:0]            wstrb;
  logic                  wlast;
  logic                  bready;
  logic                  arvalid;
  ninjin_pkg::haddr_t    araddr;
  logic [7:0]            arlen;
  logic [2:0]            arsize;
  logic [1:0]            arburst;
  logic                  rready;

  // testdata image and run bookkeeping
  logic [31:0]           td [0:127];
  int                    n_cmd      = 0;
  int                    cmd_idx    = 0;
  int                    value_errs = 0;
  int                    other_errs = 0;
  int                    cycles     = 0;
  int                    limit      = 200;
  int                    done_count = 0;

  // monitor state for the running command
  ninjin_pkg::haddr_t    cur_host;
  logic [7:0]            cur_num;
  ninjin_pkg::ddr_mode_t cur_mode;
  ninjin_pkg::err_t      cur_err;
  logic                  started = 1'b0;
  int                    aw_k;
  int                    ar_k;
  int                    w_beat;
  int                    w_total;
  int                    r_total;

  ninjin_image_dma #(
    .BURST_LEN (BURST_LEN),
    .MEMSIZE   (MEMSIZE)
  ) u_ninjin_image_dma (
    .clk        (clk),
    .xrst       (xrst),
    .start      (start),
    .mode       (mode),
    .host_base  (host_base),
    .local_base (local_base),
    .burst_num  (burst_num),
    .busy       (busy),
    .done       (done),
    .err        (err),
    .awready    (awready),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rlast      (rlast),
    .rvalid     (rvalid),
    .awvalid    (awvalid),
    .awaddr     (awaddr),
    .awlen      (awlen),
    .awsize     (awsize),
    .awburst    (awburst),
    .wvalid     (wvalid),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wlast      (wlast),
    .bready     (bready),
    .arvalid    (arvalid),
    .araddr     (araddr),
    .arlen      (arlen),
    .arsize     (arsize),
    .arburst    (arburst),
    .rready     (rready)
  );

  tb_axi_mem #(
    .BURST_LEN (BURST_LEN)
  ) u_axi_mem (
    .clk        (clk),
    .xrst       (xrst),
    .fail_burst (fail_burst),
    .awvalid    (awvalid),
    .awaddr     (awaddr),
    .awready    (awready),
    .wvalid     (wvalid),
    .wdata      (wdata),
    .wlast      (wlast),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .arvalid    (arvalid),
    .araddr     (araddr),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rlast      (rlast),
    .rvalid     (rvalid),
    .rready     (rready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //============================================================
  // compare tasks
  //============================================================
  task automatic check_word(input ninjin_pkg::word_t got, input ninjin_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_err(input ninjin_pkg::err_t got, input ninjin_pkg::err_t exp,
                           input string what);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input ninjin_pkg::haddr_t got, input ninjin_pkg::haddr_t exp,
                            input string what);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_len(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_field(input logic [3:0] got, input logic [3:0] exp, input string what);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      value_errs++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      value_errs++;
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  //============================================================
  // stimulus helpers
  //============================================================
  task automatic load_host();
    for (int i = 0; i < 1024; i++) begin
      u_axi_mem.mem[i] = 32'hc0de_0000 | 32'(i);
    end
    for (int i = 0; i < N_HOST; i++) begin
      u_axi_mem.mem[i] = td[HOST_OFS + i];
    end
  endtask

  task automatic check_reset_state();
    check_flag(awvalid, 1'b0, "awvalid in reset");
    check_flag(wvalid, 1'b0, "wvalid in reset");
    check_flag(bready, 1'b0, "bready in reset");
    check_flag(arvalid, 1'b0, "arvalid in reset");
    check_flag(rready, 1'b0, "rready in reset");
    check_flag(busy, 1'b0, "busy in reset");
    check_flag(done, 1'b0, "done in reset");
    check_flag(u_ninjin_image_dma.ddr_req, 1'b0, "ddr_req in reset");
    check_flag(u_ninjin_image_dma.ddr_we, 1'b0, "ddr_we in reset");
    check_flag(u_ninjin_image_dma.burst_done, 1'b0, "burst_done in reset");
    check_err(err, '0, "err in reset");
  endtask

  task automatic run_cmd(input int c);
    int base;
    base = 1 + c * CMD_FIELDS;
    @(posedge clk);
    cmd_idx    <= c;
    mode       <= ninjin_pkg::ddr_mode_t'(td[base][0]);
    host_base  <= td[base + 1];
    local_base <= ninjin_pkg::laddr_t'(td[base + 2]);
    burst_num  <= td[base + 3][7:0];
    fail_burst <= td[base + 4][7:0];
    start      <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    // busy must hold through the done cycle
    while (!done) begin
      @(posedge clk);
      check_flag(busy, 1'b1, "busy during command");
    end
    @(posedge clk);
    check_flag(busy, 1'b0, "busy after done");
  endtask

  task automatic check_copies();
    int base;
    int src;
    int dst;
    int n;
    for (int c = 0; c < n_cmd; c++) begin
      base = 1 + c * CMD_FIELDS;
      if (td[base + 6] != 32'hffff) begin
        src = td[base + 6];
        dst = td[base + 1] >> 2;
        n   = td[base + 3] * BURST_LEN;
        for (int i = 0; i < n; i++) begin
          check_word(u_axi_mem.mem[dst + i], td[HOST_OFS + src + i],
                     $sformatf("host word %0d", dst + i));
        end
      end
    end
  endtask

  //============================================================
  // bus monitor
  //============================================================
  always @(posedge clk) begin
    if (xrst) begin
      // err cleared one cycle after the start is taken
      if (started) begin
        check_err(err, '0, "err after start");
        started = 1'b0;
      end
      if (start && !busy) begin
        started  = 1'b1;
        cur_host = host_base;
        cur_num  = burst_num;
        cur_mode = mode;
        cur_err  = ninjin_pkg::err_t'(td[1 + cmd_idx * CMD_FIELDS + 5]);
        aw_k     = 0;
        ar_k     = 0;
        w_beat   = 0;
        w_total  = 0;
        r_total  = 0;
      end
      if (awvalid && awready) begin
        check_addr(awaddr, cur_host + ninjin_pkg::haddr_t'(aw_k * BURST_LEN * 4), "awaddr");
        check_len(awlen, 8'(BURST_LEN - 1), "awlen");
        check_field(4'(awsize), 4'(SIZE_EXP), "awsize");
        check_field(4'(awburst), 4'(BURST_INCR), "awburst");
        aw_k++;
      end
      if (arvalid && arready) begin
        check_addr(araddr, cur_host + ninjin_pkg::haddr_t'(ar_k * BURST_LEN * 4), "araddr");
        check_len(arlen, 8'(BURST_LEN - 1), "arlen");
        check_field(4'(arsize), 4'(SIZE_EXP), "arsize");
        check_field(4'(arburst), 4'(BURST_INCR), "arburst");
        ar_k++;
      end
      if (wvalid && wready) begin
        check_field(wstrb, STRB_ALL, "wstrb");
        if (wlast != (w_beat == BURST_LEN - 1)) begin
          other_errs++;
          $display("wlast in the wrong beat: beat %0d of burst %0d has wlast %b",
                   w_beat, aw_k - 1, wlast);
        end
        w_beat = (w_beat == BURST_LEN - 1) ? 0 : w_beat + 1;
        w_total++;
      end
      if (rvalid && rready) begin
        r_total++;
      end
      if (done) begin
        done_count++;
        check_err(err, cur_err, "err at done");
        if (cur_mode == ninjin_pkg::DDR_WRITE) begin
          check_count(w_total, cur_num * BURST_LEN, "write beats");
        end else begin
          check_count(r_total, cur_num * BURST_LEN, "read beats");
        end
      end
    end
  end

  // watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, command %0d never reached done", cycles, cmd_idx);
      $display("Simulation FAILED");
      $finish;
    end
  end

  //============================================================
  // main sequence
  //============================================================
  initial begin
    void'($urandom(32'h3a7a_3842));
    xrst       = 1'b0;
    start      = 1'b0;
    mode       = ninjin_pkg::DDR_READ;
    host_base  = '0;
    local_base = '0;
    burst_num  = '0;
    fail_burst = 8'hff;
    $readmemh("ninjin_testdata.txt", td);
    n_cmd = td[0];
    for (int c = 0; c < n_cmd; c++) begin
      limit += td[1 + c * CMD_FIELDS + 3] * BURST_LEN * 8;
    end
    load_host();
    repeat (16) @(posedge clk);
    check_reset_state();
    xrst <= 1'b1;
    for (int c = 0; c < n_cmd; c++) begin
      run_cmd(c);
    end
    repeat (4) @(posedge clk);
    check_count(done_count, n_cmd, "done pulses");
    check_copies();
    $display("%0d value errors, %0d other failures over %0d commands",
             value_errs, other_errs, n_cmd);
    if (value_errs + other_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
